/* Makefile */
# Verilator build and run of the decode stage testbench
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
verilog/rv_pkg.sv
verilog/dec_if.sv
verilog/id_ctrl.sv
verilog/reg_file.sv
verilog/imm_gen.sv
verilog/alu_decode.sv
verilog/branch_unit.sv
verilog/id_pipe_reg.sv
verilog/id_stage.sv
verif/tb_id_stage.sv

/* verif/tb_id_stage.sv */
//**************************************************************************
// testbench for the decode stage, random RV32I stream against a reference
//**************************************************************************
module tb_id_stage;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_RAND   = 400;
	localparam int MAX_CYCLES = 4 * 600;		// full run is under 500 cycles
	localparam rv_pkg::word_t JAL_INSTR = 32'h0080_00EF;	// jal x1, +8

	typedef struct packed {
		rv_pkg::word_t   rs1, rs2, imm, pc, target;
		rv_pkg::opcode_t op;
		rv_pkg::func3_t  f3;
		rv_pkg::alu_op_e alu;
		logic            taken;
	} dec_t;

	logic clk = 1'b0;
	logic rst_n;
	rv_pkg::word_t    i_instr, i_pc, i_write_data;
	logic             i_ce, i_stall, i_wr;
	rv_pkg::reg_idx_t i_rd_wr;
	rv_pkg::word_t    o_rs1_data, o_rs2_data, o_imm, o_pc, o_branch_pc;
	rv_pkg::opcode_t  o_opcode;
	rv_pkg::func3_t   o_func3;
	rv_pkg::alu_op_e  o_alu_op;
	logic             o_ce, o_flush, o_stall;

	logic [15:0]   lfsr = 16'd41;
	rv_pkg::word_t mirror [32] = '{default: '0};	// model of the register file
	rv_pkg::opcode_t fmt_tbl [9] = '{rv_pkg::OP_LUI, rv_pkg::OP_AUIPC, rv_pkg::OP_JAL,
		rv_pkg::OP_JALR, rv_pkg::OP_BRANCH, rv_pkg::OP_LOAD, rv_pkg::OP_STORE,
		rv_pkg::OP_IMM, rv_pkg::OP_REG};
	dec_t cur = '0;		// decode of the word driven this cycle
	dec_t held = '0;	// what the ID/EX register should show
	logic cur_acc = 1'b0;
	logic cur_stall = 1'b0;
	logic held_ce = 1'b0;
	logic checking = 1'b0;
	int   n_checks = 0;
	int   n_errors = 0;
	int   cycles = 0;

	id_stage id_stage_i (.*);

	initial begin
		forever #10 clk = ~clk;	// 20 ns period
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output rv_pkg::word_t v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};	// one step per bit
		end
	endtask

	function automatic rv_pkg::word_t r_instr(input rv_pkg::reg_idx_t rs1,
			input rv_pkg::reg_idx_t rs2);
		return {7'b0, rs2, rs1, 3'b000, 5'd1, rv_pkg::OP_REG};	// add x1, rs1, rs2
	endfunction

	// random legal word, fields random, func3 / func7 patched per format
	task automatic gen_instr(output rv_pkg::word_t ins);
		rv_pkg::word_t   raw;
		rv_pkg::word_t   sel;
		rv_pkg::opcode_t op;
		rand_bits(32, raw);
		rand_bits(5, sel);
		op  = fmt_tbl[int'(sel[3:0]) % 9];
		ins = {raw[31:7], op};
		case (op)
			rv_pkg::OP_REG:
				ins[31:25] = {1'b0, raw[30] & (ins[14:12] == 3'b000 || ins[14:12] == 3'b101),
					5'b0};	// sub and sra only
			rv_pkg::OP_IMM:
				if (ins[13:12] == 2'b01) ins[31:25] = {1'b0, raw[30] & ins[14], 5'b0};
			rv_pkg::OP_BRANCH: begin
				if (ins[14:13] == 2'b01) ins[14] = 1'b1;	// no func3 010 / 011
				if (sel[4]) ins[24:20] = ins[19:15];		// rs1 == rs2 now and then
			end
			rv_pkg::OP_JALR: ins[14:12] = 3'b000;
			rv_pkg::OP_LOAD:
				if (ins[13:12] == 2'b11 || ins[14:13] == 2'b11) ins[14:12] = 3'b010;
			rv_pkg::OP_STORE:
				ins[14:12] = {1'b0, (ins[13:12] == 2'b11) ? 2'b10 : ins[13:12]};
			default: ;
		endcase
	endtask

	// expected decode from the RV32I rules, a and b are the register values
	function automatic dec_t ref_decode(input rv_pkg::word_t ins, pc, a, b);
		dec_t r;
		logic lt_u;
		logic lt_s;
		r     = '0;
		r.rs1 = a;
		r.rs2 = b;
		r.pc  = pc;
		r.op  = ins[6:0];
		r.f3  = ins[14:12];
		lt_u  = a < b;
		lt_s  = (a[31] != b[31]) ? a[31] : lt_u;	// signs differ, the negative one is less
		case (r.op)
			rv_pkg::OP_IMM, rv_pkg::OP_LOAD, rv_pkg::OP_JALR: r.imm = {{20{ins[31]}}, ins[31:20]};
			rv_pkg::OP_STORE:  r.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			rv_pkg::OP_BRANCH: r.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			rv_pkg::OP_LUI, rv_pkg::OP_AUIPC: r.imm = {ins[31:12], 12'h000};
			rv_pkg::OP_JAL: r.imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			default: r.imm = '0;
		endcase
		r.alu = (r.op == rv_pkg::OP_LUI) ? rv_pkg::PASS_B : rv_pkg::ADD;
		if (r.op == rv_pkg::OP_REG || r.op == rv_pkg::OP_IMM) begin
			case (r.f3)
				3'd0: r.alu = (r.op == rv_pkg::OP_REG && ins[30]) ? rv_pkg::SUB : rv_pkg::ADD;
				3'd1: r.alu = rv_pkg::SLL;
				3'd2: r.alu = rv_pkg::SLT;
				3'd3: r.alu = rv_pkg::SLTU;
				3'd4: r.alu = rv_pkg::XOR;
				3'd5: r.alu = ins[30] ? rv_pkg::SRA : rv_pkg::SRL;
				3'd6: r.alu = rv_pkg::OR;
				default: r.alu = rv_pkg::AND;
			endcase
		end
		// func3 bit 0 inverts, bit 2 picks a compare, bit 1 unsigned
		if (r.op == rv_pkg::OP_BRANCH) r.taken = r.f3[0] ^ (r.f3[2] ? (r.f3[1] ? lt_u : lt_s) : (a == b));
		else r.taken = (r.op == rv_pkg::OP_JAL) || (r.op == rv_pkg::OP_JALR);
		r.target = (r.op == rv_pkg::OP_JALR) ? ((a + r.imm) & ~32'h1) : pc + r.imm;
		return r;
	endfunction

	task automatic check_word(input string name, input rv_pkg::word_t exp_v, act);
		n_checks++;
		if (act !== exp_v) begin
			n_errors++;
			$display("** Error %s: expected %h, actual %h", name, exp_v, act);
		end
	endtask

	task automatic check_alu(input string name, input rv_pkg::alu_op_e exp_v, act);
		n_checks++;
		if (act !== exp_v) begin
			n_errors++;
			$display("** Error %s: expected %h, actual %h", name, exp_v, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp_v, act);
		n_checks++;
		if (act !== exp_v) begin
			n_errors++;
			$display("** Error %s: expected %h, actual %h", name, exp_v, act);
		end
	endtask

	// one cycle of stimulus, the mirror is read before this cycle's write lands
	task automatic drive(input rv_pkg::word_t ins, pc, input logic ce, stall, wr,
			input rv_pkg::reg_idx_t rd, input rv_pkg::word_t wd);
		@(posedge clk);
		i_instr      <= ins;
		i_pc         <= pc;
		i_ce         <= ce;
		i_stall      <= stall;
		i_wr         <= wr;
		i_rd_wr      <= rd;
		i_write_data <= wd;
		cur_acc   = ce & ~stall;
		cur_stall = stall;
		cur       = ref_decode(ins, pc, mirror[ins[19:15]], mirror[ins[24:20]]);
		if (wr && rd != '0) mirror[rd] = wd;	// x0 never written
	endtask

	// mid-cycle compare, registered side first, then the same-cycle outputs
	always @(negedge clk) begin
		if (checking) begin
			check_bit("o_ce", held_ce, o_ce);
			check_word("o_rs1_data", held.rs1, o_rs1_data);
			check_word("o_rs2_data", held.rs2, o_rs2_data);
			check_word("o_imm", held.imm, o_imm);
			check_word("o_pc", held.pc, o_pc);
			check_word("o_opcode", {25'b0, held.op}, {25'b0, o_opcode});
			check_word("o_func3", {29'b0, held.f3}, {29'b0, o_func3});
			check_alu("o_alu_op", held.alu, o_alu_op);
			check_bit("o_stall", cur_stall, o_stall);
			check_bit("o_flush", cur_acc & cur.taken, o_flush);
			if (cur_acc) check_word("o_branch_pc", cur.target, o_branch_pc);
			held_ce = cur_acc;
			if (cur_acc) held = cur;	// stall or idle holds
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout, run did not reach its end within %0d cycles", MAX_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		rv_pkg::word_t ins;
		rv_pkg::word_t pc;
		rv_pkg::word_t ctl;
		rv_pkg::word_t rd;
		rv_pkg::word_t wd;
		rst_n        = 1'b0;
		i_instr      = '0;
		i_pc         = '0;
		i_ce         = 1'b0;
		i_stall      = 1'b0;
		i_wr         = 1'b0;
		i_rd_wr      = '0;
		i_write_data = '0;
		repeat (8) @(posedge clk);
		rst_n   <= 1'b1;
		checking = 1'b1;
		for (int i = 0; i < 32; i++) begin	// all registers zero after reset
			drive(r_instr(5'(i), 5'(31 - i)), 32'h100, 1'b1, 1'b0, 1'b0, '0, '0);
		end
		// fill every register, rs1 sees the old value, rs2 the one written before
		for (int i = 0; i < 32; i++) begin
			rand_bits(32, wd);
			drive(r_instr(5'(i), 5'(i - 1)), 32'h200, 1'b1, 1'b0, 1'b1, 5'(i), wd);
		end
		repeat (NUM_RAND) begin
			gen_instr(ins);
			rand_bits(32, pc);
			rand_bits(5, ctl);
			rand_bits(5, rd);
			rand_bits(32, wd);
			drive(ins, {pc[31:2], 2'b00}, ctl[2:0] != 3'b000, &ctl[3:1], ctl[4], rd[4:0], wd);
		end
		drive(JAL_INSTR, 32'h2F0, 1'b1, 1'b0, 1'b0, '0, '0);
		repeat (4) drive(JAL_INSTR, 32'h300, 1'b1, 1'b1, 1'b0, '0, '0);	// stalled jump
		repeat (3) drive(JAL_INSTR, 32'h304, 1'b0, 1'b0, 1'b0, '0, '0);	// stage idle
		repeat (2) drive(rv_pkg::NOP_INSTR, '0, 1'b0, 1'b0, 1'b0, '0, '0);
		repeat (2) @(posedge clk);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* verilog/alu_decode.sv */
//**************************************************************************
// ALU operation from opcode, func3 and func7 bit 5
//**************************************************************************
module alu_decode (
	dec_if.dp                dec,
	output rv_pkg::alu_op_e  o_alu_op
);

	logic sub_sel;	// only reg-reg has a sub form
	logic is_arith;

	assign sub_sel  = (dec.opcode == rv_pkg::OP_REG) & dec.func7b5;
	assign is_arith = (dec.opcode == rv_pkg::OP_REG) | (dec.opcode == rv_pkg::OP_IMM);

	always_comb begin
		o_alu_op = rv_pkg::ADD;	// loads, stores, branches, jumps, auipc
		if (is_arith) begin
			case (dec.func3)
				3'b000:  o_alu_op = sub_sel ? rv_pkg::SUB : rv_pkg::ADD;
				3'b001:  o_alu_op = rv_pkg::SLL;
				3'b010:  o_alu_op = rv_pkg::SLT;
				3'b011:  o_alu_op = rv_pkg::SLTU;
				3'b100:  o_alu_op = rv_pkg::XOR;
				3'b101:  o_alu_op = dec.func7b5 ? rv_pkg::SRA : rv_pkg::SRL;	// both forms
				3'b110:  o_alu_op = rv_pkg::OR;
				default: o_alu_op = rv_pkg::AND;
			endcase
		end else if (dec.opcode == rv_pkg::OP_LUI) begin
			o_alu_op = rv_pkg::PASS_B;
		end
	end

endmodule

/* verilog/branch_unit.sv */
//**************************************************************************
// branch condition and branch / jump target, resolved in decode
//**************************************************************************
module branch_unit #(
	parameter int DATA_W = rv_pkg::XLEN
) (
	dec_if.dp             dec,
	input  rv_pkg::word_t i_pc,
	input  rv_pkg::word_t i_rs1_data,
	input  rv_pkg::word_t i_rs2_data,
	input  rv_pkg::word_t i_imm,
	output logic          o_taken,
	output rv_pkg::word_t o_target
);

	logic          cond;
	logic          is_jalr;
	rv_pkg::word_t sum;

	always_comb begin
		case (dec.func3)
			3'b000:  cond = (i_rs1_data == i_rs2_data);	// beq
			3'b001:  cond = (i_rs1_data != i_rs2_data);	// bne
			3'b100:  cond = ($signed(i_rs1_data) <  $signed(i_rs2_data));
			3'b101:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
			3'b110:  cond = (i_rs1_data <  i_rs2_data);	// bltu
			3'b111:  cond = (i_rs1_data >= i_rs2_data);	// bgeu
			default: cond = 1'b0;
		endcase
	end

	assign is_jalr = (dec.opcode == rv_pkg::OP_JALR);

	assign o_taken = (dec.opcode == rv_pkg::OP_JAL) | is_jalr |
		((dec.opcode == rv_pkg::OP_BRANCH) & cond);

	assign sum      = (is_jalr ? i_rs1_data : i_pc) + i_imm;	// one shared adder
	assign o_target = is_jalr ? (sum & {{(DATA_W-1){1'b1}}, 1'b0}) : sum;

endmodule

/* verilog/dec_if.sv */
//**************************************************************************
// decoded instruction fields, driven by id_ctrl, read by the datapath blocks
//**************************************************************************
interface dec_if;

	rv_pkg::word_t    instr;	// nop when the stage is not loading
	rv_pkg::opcode_t  opcode;
	rv_pkg::func3_t   func3;
	logic             func7b5;	// sub / sra select
	rv_pkg::reg_idx_t rs1;
	rv_pkg::reg_idx_t rs2;
	rv_pkg::reg_idx_t rd;

	modport ctrl (output instr, opcode, func3, func7b5, rs1, rs2, rd);
	modport dp   (input  instr, opcode, func3, func7b5, rs1, rs2, rd);

endinterface

/* verilog/id_ctrl.sv */
//**************************************************************************
// decode control: field extraction, load enable, flush and the valid flag
//**************************************************************************
module id_ctrl (
	input  logic          clk,
	input  logic          rst_n,
	input  rv_pkg::word_t i_instr,
	input  logic          i_ce,		// stage enable from fetch
	input  logic          i_stall,	// stall from execute
	input  logic          i_taken,	// branch or jump resolved taken
	dec_if.ctrl           dec,
	output logic          o_load_en,
	output logic          o_ce,
	output logic          o_flush,
	output logic          o_stall
);

	rv_pkg::word_t d_instr;

	assign o_load_en = i_ce & ~i_stall;

	// idle or stalled stage decodes a nop, so no stray taken
	assign d_instr = o_load_en ? i_instr : rv_pkg::NOP_INSTR;

	assign dec.instr   = d_instr;
	assign dec.opcode  = d_instr[6:0];
	assign dec.rd      = d_instr[11:7];
	assign dec.func3   = d_instr[14:12];
	assign dec.rs1     = d_instr[19:15];
	assign dec.rs2     = d_instr[24:20];
	assign dec.func7b5 = d_instr[30];

	// fetch drops its in-flight word, the jump itself still goes to EX
	assign o_flush = i_taken & o_load_en;
	assign o_stall = i_stall;	// straight back to fetch

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_ce <= 1'b0;
		end else begin
			o_ce <= i_ce & ~i_stall;	// bubble into EX on stall
		end
	end

endmodule

/* verilog/id_pipe_reg.sv */
//**************************************************************************
// ID/EX pipeline register, loads on load enable and holds otherwise
//**************************************************************************
module id_pipe_reg #(
	parameter int DATA_W = rv_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            i_load_en,
	input  rv_pkg::word_t   i_rs1_data,
	input  rv_pkg::word_t   i_rs2_data,
	input  rv_pkg::word_t   i_imm,
	input  rv_pkg::word_t   i_pc,
	dec_if.dp               dec,
	input  rv_pkg::alu_op_e i_alu_op,
	output rv_pkg::word_t   o_rs1_data,
	output rv_pkg::word_t   o_rs2_data,
	output rv_pkg::word_t   o_imm,
	output rv_pkg::word_t   o_pc,
	output rv_pkg::opcode_t o_opcode,
	output rv_pkg::func3_t  o_func3,
	output rv_pkg::alu_op_e o_alu_op
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_rs1_data <= {DATA_W{1'b0}};
			o_rs2_data <= {DATA_W{1'b0}};
			o_imm      <= {DATA_W{1'b0}};
			o_pc       <= {DATA_W{1'b0}};
			o_opcode   <= '0;
			o_func3    <= '0;
			o_alu_op   <= rv_pkg::ADD;	// encodes as zero
		end else if (i_load_en) begin	// stalled or idle holds
			o_rs1_data <= i_rs1_data;
			o_rs2_data <= i_rs2_data;
			o_imm      <= i_imm;
			o_pc       <= i_pc;
			o_opcode   <= dec.opcode;
			o_func3    <= dec.func3;
			o_alu_op   <= i_alu_op;
		end
	end

endmodule

/* verilog/id_stage.sv */
//**************************************************************************
// RV32I instruction decode stage top, sits between fetch and execute
// decodes, reads operands, resolves branches and registers for EX
//**************************************************************************
module id_stage #(
	parameter int DATA_W = rv_pkg::XLEN,
	parameter int IDX_W  = rv_pkg::REG_IDX_W
) (
	input  logic             clk,
	input  logic             rst_n,
	input  rv_pkg::word_t    i_instr,		// from fetch
	input  rv_pkg::word_t    i_pc,
	input  logic             i_ce,
	input  logic             i_stall,		// from execute
	input  logic             i_wr,			// write-back port
	input  rv_pkg::reg_idx_t i_rd_wr,
	input  rv_pkg::word_t    i_write_data,
	output rv_pkg::word_t    o_rs1_data,
	output rv_pkg::word_t    o_rs2_data,
	output rv_pkg::word_t    o_imm,
	output rv_pkg::opcode_t  o_opcode,
	output rv_pkg::func3_t   o_func3,
	output rv_pkg::alu_op_e  o_alu_op,
	output rv_pkg::word_t    o_pc,
	output logic             o_ce,
	output rv_pkg::word_t    o_branch_pc,	// same cycle, to fetch
	output logic             o_flush,
	output logic             o_stall
);

	rv_pkg::word_t   rs1_data;
	rv_pkg::word_t   rs2_data;
	rv_pkg::word_t   imm;
	rv_pkg::alu_op_e alu_op;
	logic            taken;
	logic            load_en;

	dec_if dec ();

	id_ctrl ctrl_i (
		.clk(clk), .rst_n(rst_n),
		.i_instr(i_instr), .i_ce(i_ce), .i_stall(i_stall), .i_taken(taken),
		.dec(dec.ctrl),
		.o_load_en(load_en), .o_ce(o_ce), .o_flush(o_flush), .o_stall(o_stall)
	);

	reg_file #(.DATA_W(DATA_W), .IDX_W(IDX_W)) rf_i (
		.clk(clk), .rst_n(rst_n),
		.i_wr(i_wr), .i_rd_wr(i_rd_wr), .i_write_data(i_write_data),
		.dec(dec.dp),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
	);

	imm_gen #(.DATA_W(DATA_W)) imm_i (.dec(dec.dp), .o_imm(imm));

	alu_decode alu_dec_i (.dec(dec.dp), .o_alu_op(alu_op));

	branch_unit #(.DATA_W(DATA_W)) br_i (
		.dec(dec.dp),
		.i_pc(i_pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm),
		.o_taken(taken), .o_target(o_branch_pc)
	);

	id_pipe_reg #(.DATA_W(DATA_W)) pipe_i (
		.clk(clk), .rst_n(rst_n), .i_load_en(load_en),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm), .i_pc(i_pc),
		.dec(dec.dp), .i_alu_op(alu_op),
		.o_rs1_data(o_rs1_data), .o_rs2_data(o_rs2_data), .o_imm(o_imm),
		.o_pc(o_pc), .o_opcode(o_opcode), .o_func3(o_func3), .o_alu_op(o_alu_op)
	);

endmodule

/* verilog/imm_gen.sv */
//**************************************************************************
// sign-extended immediate, format picked from the opcode
//**************************************************************************
module imm_gen #(
	parameter int DATA_W = rv_pkg::XLEN
) (
	dec_if.dp             dec,
	output rv_pkg::word_t o_imm
);

	rv_pkg::word_t ins;

	assign ins = dec.instr;

	always_comb begin
		case (dec.opcode)
			rv_pkg::OP_IMM, rv_pkg::OP_LOAD, rv_pkg::OP_JALR:	// I type
				o_imm = {{(DATA_W-12){ins[31]}}, ins[31:20]};
			rv_pkg::OP_STORE:	// S type, split field
				o_imm = {{(DATA_W-12){ins[31]}}, ins[31:25], ins[11:7]};
			rv_pkg::OP_BRANCH:	// B type, halfword offset
				o_imm = {{(DATA_W-13){ins[31]}}, ins[31], ins[7],
					ins[30:25], ins[11:8], 1'b0};
			rv_pkg::OP_LUI, rv_pkg::OP_AUIPC:
				o_imm = {ins[31:12], 12'b0};	// upper 20 bits
			rv_pkg::OP_JAL:	// J type
				o_imm = {{(DATA_W-21){ins[31]}}, ins[31], ins[19:12],
					ins[20], ins[30:21], 1'b0};
			default:
				o_imm = '0;	// R type and anything unsupported
		endcase
	end

endmodule

/* verilog/reg_file.sv */
//**************************************************************************
// 32 x DATA_W register file, two async reads, one write port from write-back
//**************************************************************************
module reg_file #(
	parameter int DATA_W = rv_pkg::XLEN,
	parameter int IDX_W  = rv_pkg::REG_IDX_W
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_wr,
	input  rv_pkg::reg_idx_t i_rd_wr,
	input  rv_pkg::word_t    i_write_data,
	dec_if.dp                dec,
	output rv_pkg::word_t    o_rs1_data,
	output rv_pkg::word_t    o_rs2_data
);

	logic [DATA_W-1:0] regs [32];	// depth fixed by the ISA

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr && i_rd_wr != {IDX_W{1'b0}}) begin	// x0 stays zero
			regs[i_rd_wr] <= i_write_data;
		end
	end

	// no bypass, a same-cycle write shows up next cycle
	assign o_rs1_data = (dec.rs1 == {IDX_W{1'b0}}) ? '0 : regs[dec.rs1];
	assign o_rs2_data = (dec.rs2 == {IDX_W{1'b0}}) ? '0 : regs[dec.rs2];

endmodule

/* verilog/rv_pkg.sv */
//**************************************************************************
// shared types, RV32I opcodes and ALU operation codes for the decode stage
// referenced by scoped name from every design file
//**************************************************************************
package rv_pkg;

	parameter int XLEN      = 32;		// default data width
	parameter int REG_IDX_W = 5;		// default register index width

	typedef logic [XLEN-1:0]      word_t;		// data, pc or instruction
	typedef logic [REG_IDX_W-1:0] reg_idx_t;	// x0..x31
	typedef logic [6:0]           opcode_t;
	typedef logic [2:0]           func3_t;

	// major opcodes, bits [6:0] of the instruction
	parameter opcode_t OP_LUI    = 7'b0110111;
	parameter opcode_t OP_AUIPC  = 7'b0010111;
	parameter opcode_t OP_JAL    = 7'b1101111;
	parameter opcode_t OP_JALR   = 7'b1100111;
	parameter opcode_t OP_BRANCH = 7'b1100011;
	parameter opcode_t OP_LOAD   = 7'b0000011;
	parameter opcode_t OP_STORE  = 7'b0100011;
	parameter opcode_t OP_IMM    = 7'b0010011;
	parameter opcode_t OP_REG    = 7'b0110011;

	// ALU operation handed to execute
	typedef enum logic [3:0] {
		ADD    = 4'd0,	// also address and link arithmetic
		SUB    = 4'd1,
		SLL    = 4'd2,
		SLT    = 4'd3,
		SLTU   = 4'd4,
		XOR    = 4'd5,
		SRL    = 4'd6,
		SRA    = 4'd7,
		OR     = 4'd8,
		AND    = 4'd9,
		PASS_B = 4'd10	// lui, immediate straight through
	} alu_op_e;

	parameter word_t NOP_INSTR = 32'h0000_0013;	// addi x0,x0,0

endpackage
